//--- logic/mini_pipe_pkg.sv
`default_nettype none

package mini_pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS2
    } alu_op_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_kind_e;

    // per-instruction control, zero means a bubble
    typedef struct packed {
        alu_op_e  alu_op;
        op2_sel_e op2_sel;
        br_kind_e br_kind;
        wb_sel_e  wb_sel;
        logic     rf_wen;
        logic     mem_ren;
        logic     mem_wen;
        logic     halt;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } ctrl_t;

    // result held by a later stage, as seen by operand forwarding
    typedef struct packed {
        logic     valid;
        logic     can_forward;
        reg_idx_t rd;
        word_t    data;
    } fwd_t;

endpackage

`default_nettype wire

//--- logic/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire mini_pipe_pkg::word_t inst_i,
    output mini_pipe_pkg::ctrl_t      ctrl_o,
    output mini_pipe_pkg::word_t      imm_o
);

    import mini_pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        case (opcode)
            7'b0110011: begin
                ctrl_o.rs1    = inst_i[19:15];
                ctrl_o.rs2    = inst_i[24:20];
                ctrl_o.rd     = inst_i[11:7];
                ctrl_o.rf_wen = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl_o.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: ctrl_o.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: ctrl_o.alu_op = ALU_AND;
                    {7'h00, 3'b110}: ctrl_o.alu_op = ALU_OR;
                    {7'h00, 3'b100}: ctrl_o.alu_op = ALU_XOR;
                    {7'h00, 3'b010}: ctrl_o.alu_op = ALU_SLT;
                    default:         ctrl_o = '0;
                endcase
            end
            7'b0010011: begin
                // only addi among the op-imm group
                if (funct3 == 3'b000) begin
                    ctrl_o.rs1     = inst_i[19:15];
                    ctrl_o.rd      = inst_i[11:7];
                    ctrl_o.rf_wen  = 1'b1;
                    ctrl_o.op2_sel = OP2_IMM;
                    imm_o          = imm_i;
                end
            end
            7'b0110111: begin
                ctrl_o.rd      = inst_i[11:7];
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.alu_op  = ALU_PASS2;
                imm_o          = imm_u;
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin
                    ctrl_o.rs1     = inst_i[19:15];
                    ctrl_o.rd      = inst_i[11:7];
                    ctrl_o.rf_wen  = 1'b1;
                    ctrl_o.mem_ren = 1'b1;
                    ctrl_o.wb_sel  = WB_LOAD;
                    ctrl_o.op2_sel = OP2_IMM;
                    imm_o          = imm_i;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b010) begin
                    ctrl_o.rs1     = inst_i[19:15];
                    ctrl_o.rs2     = inst_i[24:20];
                    ctrl_o.mem_wen = 1'b1;
                    ctrl_o.op2_sel = OP2_IMM;
                    imm_o          = imm_s;
                end
            end
            7'b1100011: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl_o.rs1     = inst_i[19:15];
                    ctrl_o.rs2     = inst_i[24:20];
                    ctrl_o.br_kind = (funct3 == 3'b000) ? BR_BEQ : BR_BNE;
                    imm_o          = imm_b;
                end
            end
            7'b1101111: begin
                ctrl_o.rd      = inst_i[11:7];
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.br_kind = BR_JAL;
                imm_o          = imm_j;
            end
            7'b1110011: begin
                if (inst_i == 32'h0000_0073) begin
                    ctrl_o.halt = 1'b1;
                end
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  wire mini_pipe_pkg::ctrl_t ctrl_i,
    input  wire mini_pipe_pkg::word_t imm_i,
    input  wire mini_pipe_pkg::addr_t pc_i,
    input  wire mini_pipe_pkg::ctrl_t ex_ctrl_i,
    input  wire                       ex_valid_i,
    input  wire mini_pipe_pkg::fwd_t  mem_fwd_i,
    input  wire mini_pipe_pkg::fwd_t  wb_fwd_i,
    input  wire mini_pipe_pkg::word_t rs1_data_i,
    input  wire mini_pipe_pkg::word_t rs2_data_i,
    output mini_pipe_pkg::word_t      op1_o,
    output mini_pipe_pkg::word_t      op2_o,
    output mini_pipe_pkg::word_t      store_data_o,
    output logic                      hazard_stall_o
);

    import mini_pipe_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    logic  ex_load_hit;
    logic  mem_load_hit;

    // youngest producer wins
    function automatic word_t pick(reg_idx_t idx, word_t rf, fwd_t m, fwd_t w);
        if (idx == '0) begin
            return '0;
        end
        if (m.valid && m.can_forward && m.rd == idx) begin
            return m.data;
        end
        if (w.valid && w.rd == idx) begin
            return w.data;
        end
        return rf;
    endfunction

    assign rs1_val = pick(ctrl_i.rs1, rs1_data_i, mem_fwd_i, wb_fwd_i);
    assign rs2_val = pick(ctrl_i.rs2, rs2_data_i, mem_fwd_i, wb_fwd_i);

    // jal computes its link value pc + 4 in the alu
    assign op1_o = (ctrl_i.br_kind == BR_JAL) ? pc_i : rs1_val;
    assign op2_o = (ctrl_i.br_kind == BR_JAL) ? 32'd4 :
                   (ctrl_i.op2_sel == OP2_IMM) ? imm_i : rs2_val;
    assign store_data_o = rs2_val;

    assign ex_load_hit = ex_valid_i && ex_ctrl_i.mem_ren && ex_ctrl_i.rd != '0 &&
                         (ex_ctrl_i.rd == ctrl_i.rs1 || ex_ctrl_i.rd == ctrl_i.rs2);

    // a load still in memory has no data to forward yet
    assign mem_load_hit = mem_fwd_i.valid && !mem_fwd_i.can_forward && mem_fwd_i.rd != '0 &&
                          (mem_fwd_i.rd == ctrl_i.rs1 || mem_fwd_i.rd == ctrl_i.rs2);

    assign hazard_stall_o = ex_load_hit || mem_load_hit;

endmodule

`default_nettype wire

//--- logic/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire mini_pipe_pkg::ctrl_t ctrl_i,
    input  wire mini_pipe_pkg::addr_t pc_i,
    input  wire mini_pipe_pkg::word_t imm_i,
    input  wire mini_pipe_pkg::word_t op1_i,
    input  wire mini_pipe_pkg::word_t op2_i,
    output mini_pipe_pkg::word_t      alu_out_o,
    output logic                      branch_taken_o,
    output mini_pipe_pkg::addr_t      branch_target_o
);

    import mini_pipe_pkg::*;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:   alu_out_o = op1_i + op2_i;
            ALU_SUB:   alu_out_o = op1_i - op2_i;
            ALU_AND:   alu_out_o = op1_i & op2_i;
            ALU_OR:    alu_out_o = op1_i | op2_i;
            ALU_XOR:   alu_out_o = op1_i ^ op2_i;
            ALU_SLT:   alu_out_o = {31'b0, $signed(op1_i) < $signed(op2_i)};
            ALU_PASS2: alu_out_o = op2_i;
            default:   alu_out_o = op1_i + op2_i;
        endcase
    end

    always_comb begin
        case (ctrl_i.br_kind)
            BR_BEQ:  branch_taken_o = (op1_i == op2_i);
            BR_BNE:  branch_taken_o = (op1_i != op2_i);
            BR_JAL:  branch_taken_o = 1'b1;
            default: branch_taken_o = 1'b0;
        endcase
    end

    // b and j offsets are both pc relative
    assign branch_target_o = pc_i + imm_i;

endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       valid_i,
    input  wire mini_pipe_pkg::ctrl_t ctrl_i,
    input  wire mini_pipe_pkg::addr_t addr_i,
    input  wire mini_pipe_pkg::word_t wdata_i,
    input  wire                       dmem_ack_i,
    input  wire mini_pipe_pkg::word_t dmem_rdata_i,
    output logic                      dmem_req_o,
    output logic                      dmem_we_o,
    output mini_pipe_pkg::addr_t      dmem_addr_o,
    output mini_pipe_pkg::word_t      dmem_wdata_o,
    output mini_pipe_pkg::word_t      rdata_o,
    output logic                      stall_o
);

    logic access;
    logic done_q;

    assign access = valid_i && (ctrl_i.mem_ren || ctrl_i.mem_wen);

    // set for the one cycle in which the stage moves on
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else if (done_q) begin
            done_q <= 1'b0;
        end else if (access && dmem_ack_i) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (access && dmem_ack_i) begin
            rdata_o <= dmem_rdata_i;
        end
    end

    assign dmem_req_o   = access && !done_q;
    assign dmem_we_o    = ctrl_i.mem_wen;
    assign dmem_addr_o  = addr_i;
    assign dmem_wdata_o = wdata_i;
    assign stall_o      = access && !done_q;

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          wen_i,
    input  wire mini_pipe_pkg::reg_idx_t rd_i,
    input  wire mini_pipe_pkg::wb_sel_e  wb_sel_i,
    input  wire mini_pipe_pkg::word_t    alu_i,
    input  wire mini_pipe_pkg::word_t    load_i,
    input  wire mini_pipe_pkg::addr_t    pc_i,
    input  wire mini_pipe_pkg::reg_idx_t rs1_i,
    input  wire mini_pipe_pkg::reg_idx_t rs2_i,
    output mini_pipe_pkg::word_t         rs1_data_o,
    output mini_pipe_pkg::word_t         rs2_data_o,
    output mini_pipe_pkg::word_t         wdata_o
);

    import mini_pipe_pkg::*;

    word_t regs [31:1];

    always_comb begin
        case (wb_sel_i)
            WB_LOAD: wdata_o = load_i;
            WB_PC4:  wdata_o = pc_i + 32'd4;
            default: wdata_o = alu_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_i != '0) begin
            regs[rd_i] <= wdata_o;
        end
    end

    // x0 is hardwired
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- logic/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core #(
    parameter mini_pipe_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  wire                       clk,
    input  wire                       rst_n_i,
    output mini_pipe_pkg::addr_t      imem_addr_o,
    input  wire mini_pipe_pkg::word_t imem_data_i,
    output logic                      dmem_req_o,
    output logic                      dmem_we_o,
    output mini_pipe_pkg::addr_t      dmem_addr_o,
    output mini_pipe_pkg::word_t      dmem_wdata_o,
    input  wire                       dmem_ack_i,
    input  wire mini_pipe_pkg::word_t dmem_rdata_i,
    output logic                      halt_o
);

    import mini_pipe_pkg::*;

    addr_t pc_q;
    logic  fetch_off_q;

    logic  id_valid;
    addr_t id_pc;
    word_t id_inst;
    ctrl_t dec_ctrl;
    word_t dec_imm;

    logic  ds_valid;
    addr_t ds_pc;
    ctrl_t ds_ctrl;
    word_t ds_imm;
    word_t ds_op1;
    word_t ds_op2;
    word_t ds_sdata;
    logic  ds_hazard;

    logic  exe_valid;
    addr_t exe_pc;
    ctrl_t exe_ctrl;
    word_t exe_imm;
    word_t exe_op1;
    word_t exe_op2;
    word_t exe_sdata;
    word_t exe_alu;
    logic  exe_taken;
    addr_t exe_target;

    logic  mem_valid;
    addr_t mem_pc;
    ctrl_t mem_ctrl;
    word_t mem_alu;
    word_t mem_sdata;
    word_t mem_rdata;
    logic  mem_stall;

    logic  wb_valid;
    addr_t wb_pc;
    ctrl_t wb_ctrl;
    word_t wb_alu;
    word_t wb_load;
    word_t wb_wdata;

    word_t rs1_data;
    word_t rs2_data;
    fwd_t  mem_fwd;
    fwd_t  wb_fwd;

    logic  hazard;
    logic  front_hold;
    logic  br_redirect;
    logic  halt_flush;
    logic  flush;

    assign hazard      = ds_valid && ds_hazard;
    assign front_hold  = mem_stall || hazard;
    assign br_redirect = !mem_stall && exe_valid && exe_taken;
    // ecall drains what is older and kills what is younger
    assign halt_flush  = !mem_stall && exe_valid && exe_ctrl.halt;
    assign flush       = br_redirect || halt_flush;

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q        <= RESET_PC;
            fetch_off_q <= 1'b0;
            id_valid    <= 1'b0;
            ds_valid    <= 1'b0;
            exe_valid   <= 1'b0;
            mem_valid   <= 1'b0;
            wb_valid    <= 1'b0;
            halt_o      <= 1'b0;
        end else begin
            if (halt_flush) begin
                fetch_off_q <= 1'b1;
            end
            if (br_redirect) begin
                pc_q <= exe_target;
            end else if (!front_hold && !fetch_off_q && !halt_flush) begin
                pc_q <= pc_q + 32'd4;
            end
            if (flush) begin
                id_valid <= 1'b0;
                ds_valid <= 1'b0;
            end else if (!front_hold) begin
                id_valid <= !fetch_off_q;
                ds_valid <= id_valid;
            end
            if (!mem_stall) begin
                exe_valid <= ds_valid && !hazard && !flush;
                mem_valid <= exe_valid;
            end
            wb_valid <= mem_valid && !mem_stall;
            if (!mem_stall && mem_valid && mem_ctrl.halt) begin
                halt_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!front_hold) begin
            id_pc   <= pc_q;
            id_inst <= imem_data_i;
            ds_pc   <= id_pc;
            ds_ctrl <= dec_ctrl;
            ds_imm  <= dec_imm;
        end
        if (!mem_stall) begin
            exe_pc    <= ds_pc;
            exe_ctrl  <= ds_ctrl;
            exe_imm   <= ds_imm;
            exe_op1   <= ds_op1;
            exe_op2   <= ds_op2;
            exe_sdata <= ds_sdata;
            mem_pc    <= exe_pc;
            mem_ctrl  <= exe_ctrl;
            mem_alu   <= exe_alu;
            mem_sdata <= exe_sdata;
            wb_pc     <= mem_pc;
            wb_ctrl   <= mem_ctrl;
            wb_alu    <= mem_alu;
            wb_load   <= mem_rdata;
        end
    end

    assign mem_fwd = '{valid: mem_valid && mem_ctrl.rf_wen, can_forward: !mem_ctrl.mem_ren,
                       rd: mem_ctrl.rd, data: mem_alu};
    assign wb_fwd  = '{valid: wb_valid && wb_ctrl.rf_wen, can_forward: 1'b1,
                       rd: wb_ctrl.rd, data: wb_wdata};

    inst_decoder u_decoder (
        .inst_i (id_inst),
        .ctrl_o (dec_ctrl),
        .imm_o  (dec_imm)
    );

    operand_select u_operand_select (
        .ctrl_i         (ds_ctrl),
        .imm_i          (ds_imm),
        .pc_i           (ds_pc),
        .ex_ctrl_i      (exe_ctrl),
        .ex_valid_i     (exe_valid),
        .mem_fwd_i      (mem_fwd),
        .wb_fwd_i       (wb_fwd),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .op1_o          (ds_op1),
        .op2_o          (ds_op2),
        .store_data_o   (ds_sdata),
        .hazard_stall_o (ds_hazard)
    );

    execute_unit u_execute (
        .ctrl_i          (exe_ctrl),
        .pc_i            (exe_pc),
        .imm_i           (exe_imm),
        .op1_i           (exe_op1),
        .op2_i           (exe_op2),
        .alu_out_o       (exe_alu),
        .branch_taken_o  (exe_taken),
        .branch_target_o (exe_target)
    );

    load_store_unit u_lsu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (mem_valid),
        .ctrl_i       (mem_ctrl),
        .addr_i       (mem_alu),
        .wdata_i      (mem_sdata),
        .dmem_ack_i   (dmem_ack_i),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .rdata_o      (mem_rdata),
        .stall_o      (mem_stall)
    );

    register_file u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wen_i      (wb_valid && wb_ctrl.rf_wen),
        .rd_i       (wb_ctrl.rd),
        .wb_sel_i   (wb_ctrl.wb_sel),
        .alu_i      (wb_alu),
        .load_i     (wb_load),
        .pc_i       (wb_pc),
        .rs1_i      (ds_ctrl.rs1),
        .rs2_i      (ds_ctrl.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wdata_o    (wb_wdata)
    );

endmodule

`default_nettype wire

//--- tests/pipeline_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core_tb;

    import mini_pipe_pkg::*;

    localparam addr_t START_PC      = 32'h0000_0080;
    localparam int    PROG_LEN      = 40;
    localparam int    STORE_COUNT   = 12;
    localparam int    STORE_TIMEOUT = 200;
    localparam int    HALT_TIMEOUT  = 200;
    localparam int    QUIET_CYCLES  = 12;
    localparam word_t ECALL_WORD    = 32'h0000_0073;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } store_rec_t;

    logic  clk;
    logic  rst_n;
    addr_t imem_addr;
    word_t imem_data;
    logic  dmem_req;
    logic  dmem_we;
    addr_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_ack;
    word_t dmem_rdata;
    logic  halt;

    word_t       rom [0:PROG_LEN-1];
    addr_t       rom_off;
    word_t       dmem [0:255];
    store_rec_t  expected [0:STORE_COUNT-1];
    store_rec_t  seen_q [$];
    logic        waiting;
    int unsigned wait_left;
    int          errors;

    pipeline_core #(
        .RESET_PC (START_PC)
    ) u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_req_o   (dmem_req),
        .dmem_we_o    (dmem_we),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_ack_i   (dmem_ack),
        .dmem_rdata_i (dmem_rdata),
        .halt_o       (halt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // asynchronous rom, anything past the program reads as ecall
    assign rom_off   = imem_addr - START_PC;
    assign imem_data = (rom_off[31:2] < PROG_LEN) ? rom[rom_off[31:2]] : ECALL_WORD;

    // rv32i encodings
    function automatic word_t reg_op(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t imm_op(logic [6:0] opcode, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic word_t sw_op(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch_op(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                        logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jal_op(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t lui_op(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t fill_pattern(addr_t a);
        return {~a[15:0], a[15:0]} ^ {a[31:16], a[31:16]};
    endfunction

    // producers sit two or three slots ahead of their consumers
    task automatic load_program();
        rom[0]  = imm_op(7'b0010011, 3'b000, 5'd10, 5'd0, 12'h200);
        rom[1]  = imm_op(7'b0010011, 3'b000, 5'd1, 5'd0, 12'd5);
        rom[2]  = imm_op(7'b0010011, 3'b000, 5'd2, 5'd0, 12'hFFD);
        rom[3]  = lui_op(5'd5, 20'h12345);
        rom[4]  = reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        rom[5]  = imm_op(7'b0010011, 3'b000, 5'd7, 5'd0, 12'h0F0);
        rom[6]  = sw_op(5'd3, 5'd10, 12'd0);
        rom[7]  = reg_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);
        rom[8]  = imm_op(7'b0010011, 3'b000, 5'd5, 5'd5, 12'h678);
        rom[9]  = sw_op(5'd4, 5'd10, 12'd4);
        rom[10] = reg_op(7'h00, 3'b111, 5'd6, 5'd5, 5'd7);
        rom[11] = reg_op(7'h00, 3'b110, 5'd8, 5'd5, 5'd7);
        rom[12] = reg_op(7'h00, 3'b100, 5'd9, 5'd5, 5'd7);
        rom[13] = sw_op(5'd6, 5'd10, 12'd8);
        rom[14] = sw_op(5'd8, 5'd10, 12'd12);
        rom[15] = sw_op(5'd9, 5'd10, 12'd16);
        rom[16] = reg_op(7'h00, 3'b010, 5'd11, 5'd2, 5'd1);
        rom[17] = reg_op(7'h00, 3'b010, 5'd12, 5'd1, 5'd2);
        rom[18] = sw_op(5'd11, 5'd10, 12'd20);
        rom[19] = sw_op(5'd12, 5'd10, 12'd24);
        rom[20] = imm_op(7'b0010011, 3'b000, 5'd14, 5'd0, 12'h100);
        rom[21] = imm_op(7'b0010011, 3'b000, 5'd0, 5'd0, 12'd0);
        rom[22] = imm_op(7'b0000011, 3'b010, 5'd13, 5'd14, 12'd0);
        // load-use on an alu operand
        rom[23] = reg_op(7'h00, 3'b000, 5'd15, 5'd13, 5'd1);
        rom[24] = imm_op(7'b0000011, 3'b010, 5'd16, 5'd10, 12'd0);
        rom[25] = sw_op(5'd15, 5'd10, 12'd28);
        rom[26] = sw_op(5'd16, 5'd10, 12'd32);
        rom[27] = branch_op(3'b000, 5'd1, 5'd1, 13'd12);
        rom[28] = imm_op(7'b0010011, 3'b000, 5'd20, 5'd0, 12'd1);
        rom[29] = sw_op(5'd20, 5'd10, 12'd36);
        rom[30] = imm_op(7'b0010011, 3'b000, 5'd21, 5'd0, 12'h055);
        rom[31] = branch_op(3'b001, 5'd1, 5'd1, 13'd8);
        rom[32] = imm_op(7'b0010011, 3'b000, 5'd22, 5'd0, 12'h066);
        rom[33] = sw_op(5'd21, 5'd10, 12'd36);
        rom[34] = sw_op(5'd22, 5'd10, 12'd40);
        rom[35] = jal_op(5'd23, 21'd8);
        rom[36] = sw_op(5'd0, 5'd10, 12'd44);
        rom[37] = sw_op(5'd23, 5'd10, 12'd44);
        rom[38] = ECALL_WORD;
        rom[39] = sw_op(5'd1, 5'd10, 12'd48);
    endtask

    task automatic load_expected();
        expected[0]  = '{addr: 32'h0000_0200, data: 32'h0000_0002};
        expected[1]  = '{addr: 32'h0000_0204, data: 32'h0000_0008};
        expected[2]  = '{addr: 32'h0000_0208, data: 32'h0000_0070};
        expected[3]  = '{addr: 32'h0000_020C, data: 32'h1234_56F8};
        expected[4]  = '{addr: 32'h0000_0210, data: 32'h1234_5688};
        expected[5]  = '{addr: 32'h0000_0214, data: 32'h0000_0001};
        expected[6]  = '{addr: 32'h0000_0218, data: 32'h0000_0000};
        expected[7]  = '{addr: 32'h0000_021C, data: 32'h0BAD_F012};
        expected[8]  = '{addr: 32'h0000_0220, data: 32'h0000_0002};
        expected[9]  = '{addr: 32'h0000_0224, data: 32'h0000_0055};
        expected[10] = '{addr: 32'h0000_0228, data: 32'h0000_0066};
        // jal link is its own address plus 4
        expected[11] = '{addr: 32'h0000_022C, data: 32'h0000_0110};
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // data memory with a random ack delay of 0 to 3 idle cycles
    initial begin : dmem_model
        int unsigned delay;
        int unsigned seed_sink;
        seed_sink = $urandom(32);
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                dmem_ack  <= 1'b0;
                waiting   <= 1'b0;
                wait_left <= 0;
            end else begin
                dmem_ack <= 1'b0;
                if (dmem_req && !dmem_ack) begin
                    if (!waiting) begin
                        delay = $urandom % 4;
                    end else begin
                        delay = wait_left;
                    end
                    if (delay == 0) begin
                        waiting  <= 1'b0;
                        dmem_ack <= 1'b1;
                        if (dmem_we) begin
                            dmem[dmem_addr[9:2]] <= dmem_wdata;
                            seen_q.push_back('{addr: dmem_addr, data: dmem_wdata});
                        end else begin
                            dmem_rdata <= dmem[dmem_addr[9:2]];
                        end
                    end else begin
                        waiting   <= 1'b1;
                        wait_left <= delay - 1;
                    end
                end
            end
        end
    end

    initial begin : main
        int wait_cycles;
        errors     = 0;
        rst_n      = 1'b0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        waiting    = 1'b0;
        wait_left  = 0;
        load_program();
        load_expected();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_pattern(i * 4);
        end
        dmem[32'h100 >> 2] = 32'h0BAD_F00D;

        @(posedge clk);
        @(negedge clk);
        check_addr(imem_addr, START_PC, "fetch address in reset");
        check_level(dmem_req, 1'b0, "dmem_req_o in reset");
        check_level(halt, 1'b0, "halt_o in reset");
        @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < STORE_COUNT; i++) begin
            wait_cycles = 0;
            while (seen_q.size() <= i && wait_cycles < STORE_TIMEOUT) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (seen_q.size() <= i) begin
                $display("store %0d never reached the data memory", i);
                errors++;
            end else begin
                check_addr(seen_q[i].addr, expected[i].addr, $sformatf("store %0d address", i));
                check_word(seen_q[i].data, expected[i].data, $sformatf("store %0d data", i));
            end
        end

        wait_cycles = 0;
        while (!halt && wait_cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!halt) begin
            $display("halt_o never rose after the ecall");
            errors++;
        end else begin
            // nothing may reach memory once halted
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge clk);
                check_level(dmem_req, 1'b0, "dmem_req_o after halt");
            end
            check_level(halt, 1'b1, "halt_o after halt");
        end
        if (seen_q.size() != STORE_COUNT) begin
            $display("saw %0d stores where %0d were expected", seen_q.size(), STORE_COUNT);
            errors++;
        end

        $display("errors: %0d, stores seen: %0d of %0d", errors, seen_q.size(), STORE_COUNT);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mini_pipe.f
logic/mini_pipe_pkg.sv
logic/inst_decoder.sv
logic/operand_select.sv
logic/execute_unit.sv
logic/load_store_unit.sv
logic/register_file.sv
logic/pipeline_core.sv
tests/pipeline_core_tb.sv

//--- Bender.yml
package:
  name: mini_pipe

sources:
  - logic/mini_pipe_pkg.sv
  - logic/inst_decoder.sv
  - logic/operand_select.sv
  - logic/execute_unit.sv
  - logic/load_store_unit.sv
  - logic/register_file.sv
  - logic/pipeline_core.sv
  - target: test
    files:
      - tests/pipeline_core_tb.sv
